// File: project.f
source/clk_ctrl_pkg.sv
source/clk_sel_decode.sv
source/clk_fail_monitor.sv
source/sys_clk_switch.sv
source/clk_switch_status.sv
source/clk_ctrl_top.sv
sim/clk_ctrl_tb.sv

// File: Bender.yml
package:
  name: clk_ctrl

sources:
  - files:
      - source/clk_ctrl_pkg.sv
      - source/clk_sel_decode.sv
      - source/clk_fail_monitor.sv
      - source/sys_clk_switch.sv
      - source/clk_switch_status.sv
      - source/clk_ctrl_top.sv
  - target: test
    files:
      - sim/clk_ctrl_tb.sv

// File: sim/clk_ctrl_tb.sv
// testbench for the clock control subsystem
// source clock generators, random select requests against a reference model,
// output period and glitch checks, stopped-clock, back-pressure and scan tests
module clk_ctrl_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_NUM      = 4;
  localparam int FAIL_TIMEOUT = clk_ctrl_pkg::FAIL_TIMEOUT_DEF;
  localparam int REF_PERIOD   = 40;
  localparam int NUM_REQ      = 24;
  // random requests plus three per stopped-clock test
  localparam int NUM_TOTAL    = NUM_REQ + 6;
  localparam int WATCHDOG_NS  = (NUM_TOTAL * 200 + 1000) * REF_PERIOD;
  // shortest half-period of any source
  localparam int MIN_HALF     = 15;

  wire  [CLK_NUM-1:0]     i_clk;
  logic [CLK_NUM-1:0]     run;
  logic                   reset;
  logic                   req_valid;
  logic                   req_ready;
  clk_ctrl_pkg::sel_req_t req;
  logic                   rsp_valid;
  logic                   rsp_ready;
  clk_ctrl_pkg::sel_rsp_t rsp;
  logic                   scan_mode;
  logic                   test_clk;
  logic                   o_clk;

  integer                 seed = 15998;
  logic   [CLK_NUM-1:0]   model_failed;
  int                     cur_active;
  logic                   glitch_on;
  realtime                last_edge = 0.0;

  // source periods in ns
  function automatic int period_of(input int idx);
    case (idx)
      0:       return 40;
      1:       return 30;
      2:       return 56;
      default: return 72;
    endcase
  endfunction

  // ============================================================
  // clocks
  // ============================================================

  for (genvar k = 0; k < CLK_NUM; k++) begin : g_src
    logic c = 1'b0;
    // stopped source finishes its high phase and parks low
    always begin
      #(period_of(k) / 2.0);
      if (run[k] || c) begin
        c = ~c;
      end
    end
    assign i_clk[k] = c;
  end

  // scan clock, faster than any source
  always #12 test_clk = ~test_clk;

  clk_ctrl_top #(
    .CLK_NUM      (CLK_NUM),
    .FAIL_TIMEOUT (FAIL_TIMEOUT)
  ) DUT (
    .i_clk     (i_clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp),
    .scan_mode (scan_mode),
    .test_clk  (test_clk),
    .o_clk     (o_clk)
  );

  // ============================================================
  // checking helpers
  // ============================================================

  task automatic fail_run();
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
      fail_run();
    end
  endtask

  // every o_clk phase at least the shortest source half-period
  always @(o_clk) begin : glitch_watch
    realtime ph;
    ph = $realtime - last_edge;
    if (glitch_on && ph < MIN_HALF) begin
      check_value(o_clk ? "o_clk low phase" : "o_clk high phase", MIN_HALF,
                  int'($floor(ph)));
    end
    last_edge = $realtime;
  end

  // ============================================================
  // stimulus tasks, entered and left on a falling reference edge
  // ============================================================

  task automatic send_request(input int idx);
    req_valid = 1'b1;
    req.idx   = clk_ctrl_pkg::clk_idx_t'(idx);
    // ready seen at a falling edge holds through the next rising edge
    while (!req_ready) begin
      @(negedge i_clk[0]);
    end
    @(negedge i_clk[0]);
    req_valid = 1'b0;
  endtask

  task automatic collect_response(output clk_ctrl_pkg::sel_rsp_t r);
    int stall;
    while (!rsp_valid) begin
      check_value("req_ready while busy", 0, req_ready);
      @(negedge i_clk[0]);
    end
    r     = rsp;
    stall = {$random(seed)} % 5;
    // response held back, payload must not move
    repeat (stall) begin
      @(negedge i_clk[0]);
      check_value("rsp_valid under back-pressure", 1, rsp_valid);
      check_value("rsp under back-pressure", r, rsp);
      check_value("req_ready under back-pressure", 0, req_ready);
    end
    rsp_ready = 1'b1;
    @(negedge i_clk[0]);
    rsp_ready = 1'b0;
  endtask

  // average over four o_clk periods
  task automatic measure_period(output int p);
    realtime t0;
    @(posedge o_clk);
    t0 = $realtime;
    repeat (4) @(posedge o_clk);
    p = int'(($realtime - t0) / 4.0);
    @(negedge i_clk[0]);
  endtask

  task automatic run_request(input int idx);
    clk_ctrl_pkg::sel_rsp_t r;
    logic                   exp_fb;
    int                     exp_active;
    int                     p;
    // decode rule, bad index or failed source goes to clock 0
    exp_fb     = (idx >= CLK_NUM) || model_failed[idx];
    exp_active = exp_fb ? 0 : idx;
    send_request(idx);
    collect_response(r);
    check_value("rsp.active", exp_active, r.active);
    check_value("rsp.fallback", exp_fb, r.fallback);
    check_value("rsp.failed", model_failed, r.failed);
    cur_active = exp_active;
    measure_period(p);
    check_value("o_clk period", period_of(exp_active), p);
  endtask

  task automatic stopped_clock_test(input int k);
    // move off the source before it stops
    run_request(0);
    run[k] = 1'b0;
    // idle count plus sync stages
    repeat (FAIL_TIMEOUT + 8) @(negedge i_clk[0]);
    model_failed[k] = 1'b1;
    run_request(k);
    run[k] = 1'b1;
    // fail flag clears once toggles come through again
    repeat (8) @(negedge i_clk[0]);
    model_failed[k] = 1'b0;
    run_request(k);
  endtask

  task automatic scan_test();
    int p;
    glitch_on = 1'b0;
    scan_mode = 1'b1;
    repeat (8) begin
      @(test_clk);
      #1;
      check_value("o_clk follows test_clk", test_clk, o_clk);
    end
    @(negedge i_clk[0]);
    scan_mode = 1'b0;
    // skip the edge at the mux change
    repeat (2) @(posedge o_clk);
    measure_period(p);
    check_value("o_clk period after scan", period_of(cur_active), p);
    glitch_on = 1'b1;
  endtask

  // ============================================================
  // main sequence and watchdog
  // ============================================================

  initial begin
    int p;
    run          = '1;
    reset        = 1'b1;
    req_valid    = 1'b0;
    req          = '0;
    rsp_ready    = 1'b0;
    scan_mode    = 1'b0;
    test_clk     = 1'b0;
    model_failed = '0;
    cur_active   = 0;
    glitch_on    = 1'b0;
    repeat (5) @(posedge i_clk[0]);
    @(negedge i_clk[0]);
    reset = 1'b0;
    // let the source-domain reset syncs drain
    repeat (6) @(negedge i_clk[0]);
    check_value("req_ready after reset", 1, req_ready);
    check_value("rsp_valid after reset", 0, rsp_valid);
    measure_period(p);
    check_value("o_clk period after reset", period_of(0), p);
    glitch_on = 1'b1;
    for (int n = 0; n < NUM_REQ; n++) begin
      run_request({$random(seed)} % CLK_NUM);
    end
    stopped_clock_test(3);
    stopped_clock_test(1);
    scan_test();
    $display("PASS: all tests");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the DUT did not finish the tests within %0d ns", WATCHDOG_NS);
    fail_run();
  end

endmodule

// File: source/clk_ctrl_top.sv
// clock control subsystem top level
// decode, fail monitor, glitch-free switch and status
module clk_ctrl_top #(
  parameter int CLK_NUM      = 4,
  parameter int FAIL_TIMEOUT = clk_ctrl_pkg::FAIL_TIMEOUT_DEF
) (
  input  logic [CLK_NUM-1:0]     i_clk,
  input  logic                   reset,
  input  logic                   req_valid,
  output logic                   req_ready,
  input  clk_ctrl_pkg::sel_req_t req,
  output logic                   rsp_valid,
  input  logic                   rsp_ready,
  output clk_ctrl_pkg::sel_rsp_t rsp,
  input  logic                   scan_mode,
  input  logic                   test_clk,
  output logic                   o_clk
);

  clk_ctrl_pkg::clk_vec_t clk_vec;
  clk_ctrl_pkg::clk_vec_t target;
  clk_ctrl_pkg::clk_vec_t clk_fail;
  clk_ctrl_pkg::clk_vec_t d2_sel;
  logic                   busy;
  logic                   fallback;
  logic                   done;

  // unused clock slots tied low
  assign clk_vec = clk_ctrl_pkg::clk_vec_t'(i_clk);

  // ============================================================
  // control in the i_clk[0] domain
  // ============================================================

  clk_sel_decode #(
    .CLK_NUM (CLK_NUM)
  ) u_decode (
    .clk       (i_clk[0]),
    .reset     (reset),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .clk_fail  (clk_fail),
    .done      (done),
    .target    (target),
    .fallback  (fallback),
    .busy      (busy)
  );

  clk_fail_monitor #(
    .CLK_NUM      (CLK_NUM),
    .FAIL_TIMEOUT (FAIL_TIMEOUT)
  ) u_monitor (
    .clk      (i_clk[0]),
    .reset    (reset),
    .i_clk    (clk_vec),
    .clk_fail (clk_fail)
  );

  // source domains
  sys_clk_switch #(
    .CLK_NUM (CLK_NUM)
  ) u_switch (
    .i_clk     (clk_vec),
    .reset     (reset),
    .target    (target),
    .clk_fail  (clk_fail),
    .scan_mode (scan_mode),
    .test_clk  (test_clk),
    .d2_sel    (d2_sel),
    .o_clk     (o_clk)
  );

  clk_switch_status #(
    .CLK_NUM (CLK_NUM)
  ) u_status (
    .clk       (i_clk[0]),
    .reset     (reset),
    .d2_sel    (d2_sel),
    .target    (target),
    .busy      (busy),
    .fallback  (fallback),
    .clk_fail  (clk_fail),
    .rsp_ready (rsp_ready),
    .done      (done),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

endmodule

// File: source/clk_switch_status.sv
// switch completion and response channel
// two-flop sync of the enables, match against target,
// one-hot to index encode, response register and done pulse
module clk_switch_status #(
  parameter int CLK_NUM = 4
) (
  input  logic                   clk,
  input  logic                   reset,
  input  clk_ctrl_pkg::clk_vec_t d2_sel,
  input  clk_ctrl_pkg::clk_vec_t target,
  input  logic                   busy,
  input  logic                   fallback,
  input  clk_ctrl_pkg::clk_vec_t clk_fail,
  input  logic                   rsp_ready,
  output logic                   done,
  output logic                   rsp_valid,
  output clk_ctrl_pkg::sel_rsp_t rsp
);

  clk_ctrl_pkg::clk_vec_t sel_meta;
  clk_ctrl_pkg::clk_vec_t sel_sync;
  clk_ctrl_pkg::clk_idx_t act_idx;
  logic                   match;

  // enables come from the source domains
  always_ff @(posedge clk) begin
    sel_meta <= d2_sel;
    sel_sync <= sel_meta;
  end

  // one-hot to index
  always_comb begin
    act_idx = '0;
    for (int i = 0; i < CLK_NUM; i++) begin
      if (sel_sync[i]) begin
        act_idx = clk_ctrl_pkg::clk_idx_t'(i);
      end
    end
  end

  // hand-over finished, only one response per switch
  assign match = busy && !rsp_valid && (sel_sync == target);

  // frees decode for the next request
  assign done = rsp_valid && rsp_ready;

  // ============================================================
  // response channel
  // ============================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      rsp_valid <= 1'b0;
    end else if (done) begin
      rsp_valid <= 1'b0;
    end else if (match) begin
      rsp_valid <= 1'b1;
    end
  end

  // payload captured once, held through back-pressure
  always_ff @(posedge clk) begin
    if (match) begin
      rsp.active   <= act_idx;
      rsp.fallback <= fallback;
      rsp.failed   <= clk_fail;
    end
  end

  a_rsp_hold : assert property (
    @(posedge clk) disable iff (reset)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp)
  );

endmodule

// File: source/sys_clk_switch.sv
// glitch-free system clock switch
// per-domain reset sync and two-flop enables with cross interlock,
// enable gating of each source, OR of the gated clocks, scan test mux
module sys_clk_switch #(
  parameter int CLK_NUM = 4
) (
  input  clk_ctrl_pkg::clk_vec_t i_clk,
  input  logic                   reset,
  input  clk_ctrl_pkg::clk_vec_t target,
  input  clk_ctrl_pkg::clk_vec_t clk_fail,
  input  logic                   scan_mode,
  input  logic                   test_clk,
  output clk_ctrl_pkg::clk_vec_t d2_sel,
  output logic                   o_clk
);

  // second-stage enables with failed domains masked out
  wire clk_ctrl_pkg::clk_vec_t d2_w;

  clk_ctrl_pkg::clk_vec_t gated;
  logic                   func_clk;

  // ============================================================
  // per-domain enable chain
  // ============================================================

  for (genvar k = 0; k < clk_ctrl_pkg::CLK_MAX; k++) begin : g_dom
    if (k >= CLK_NUM) begin : g_off
      assign d2_w[k] = 1'b0;
    end else begin : g_on
      logic [1:0]             rst_sync;
      logic                   d1;
      logic                   d2;
      logic                   nxt;
      clk_ctrl_pkg::clk_vec_t others;

      // every domain but this one
      assign others = d2_w & ~(clk_ctrl_pkg::CLK0_VEC << k);

      // take over only once all other enables are down
      assign nxt = target[k] && !(|others);

      // local copy of reset for this source
      always_ff @(posedge i_clk[k]) begin
        rst_sync <= {rst_sync[0], reset};
      end

      // first stage on the rising edge
      always_ff @(posedge i_clk[k]) begin
        if (rst_sync[1]) begin
          // clock 0 owns the output out of reset
          d1 <= (k == 0);
        end else if (clk_fail[k]) begin
          d1 <= 1'b0;
        end else begin
          d1 <= nxt;
        end
      end

      // second stage on the falling edge, source is low after it
      always_ff @(negedge i_clk[k]) begin
        if (rst_sync[1]) begin
          d2 <= (k == 0);
        end else if (clk_fail[k]) begin
          d2 <= 1'b0;
        end else begin
          d2 <= d1;
        end
      end

      // a stopped clock cannot clear its own flops,
      // so the fail flag drops it from the hand-over directly
      assign d2_w[k] = d2 && !clk_fail[k];
    end
  end

  assign d2_sel = d2_w;

  // ============================================================
  // output gating and test mux
  // ============================================================

  // enables change only while their own clock is low
  assign gated    = i_clk & d2_w;
  assign func_clk = |gated;

  // scan replaces the functional clock
  assign o_clk = scan_mode ? test_clk : func_clk;

  // break-before-make across all source domains
  a_sel_exclusive : assert property (
    @(posedge i_clk[0]) disable iff (reset)
    !$isunknown(d2_sel) |-> $onehot0(d2_sel)
  );

endmodule

// File: source/clk_fail_monitor.sv
// stopped-clock detection in the reference domain
// per-source toggle flag, two-flop sync, idle counter, fail bit
module clk_fail_monitor #(
  parameter int CLK_NUM      = 4,
  parameter int FAIL_TIMEOUT = clk_ctrl_pkg::FAIL_TIMEOUT_DEF
) (
  input  logic                   clk,
  input  logic                   reset,
  input  clk_ctrl_pkg::clk_vec_t i_clk,
  output clk_ctrl_pkg::clk_vec_t clk_fail
);

  localparam int CNT_W = $clog2(FAIL_TIMEOUT + 1);

  wire clk_ctrl_pkg::clk_vec_t fail_w;

  for (genvar k = 0; k < clk_ctrl_pkg::CLK_MAX; k++) begin : g_mon
    if (k == 0 || k >= CLK_NUM) begin : g_off
      // reference clock and unused slots never fail
      assign fail_w[k] = 1'b0;
    end else begin : g_on
      logic [1:0]       rst_sync;
      logic             tog;
      logic [2:0]       tog_sync;
      logic [CNT_W-1:0] idle_cnt;
      logic             fail;

      // reset brought into the source domain
      always_ff @(posedge i_clk[k]) begin
        rst_sync <= {rst_sync[0], reset};
      end

      // flips on every source edge
      always_ff @(posedge i_clk[k]) begin
        if (rst_sync[1]) begin
          tog <= 1'b0;
        end else begin
          tog <= ~tog;
        end
      end

      // ======================================================
      // reference domain side
      // ======================================================
      always_ff @(posedge clk) begin
        if (reset) begin
          tog_sync <= '0;
          idle_cnt <= '0;
          fail     <= 1'b0;
        end else begin
          tog_sync <= {tog_sync[1:0], tog};
          if (tog_sync[2] != tog_sync[1]) begin
            // source alive again
            idle_cnt <= '0;
            fail     <= 1'b0;
          end else if (idle_cnt == CNT_W'(FAIL_TIMEOUT)) begin
            fail <= 1'b1;
          end else begin
            idle_cnt <= idle_cnt + 1'b1;
          end
        end
      end

      assign fail_w[k] = fail;
    end
  end

  assign clk_fail = fail_w;

endmodule

// File: source/clk_sel_decode.sv
// request decode for the clock controller
// range and health check of the requested index,
// one-hot target register, busy flag and fallback flag
module clk_sel_decode #(
  parameter int CLK_NUM = 4
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   req_valid,
  output logic                   req_ready,
  input  clk_ctrl_pkg::sel_req_t req,
  input  clk_ctrl_pkg::clk_vec_t clk_fail,
  input  logic                   done,
  output clk_ctrl_pkg::clk_vec_t target,
  output logic                   fallback,
  output logic                   busy
);

  logic                   req_bad;
  clk_ctrl_pkg::clk_vec_t req_onehot;
  logic                   accept;
  logic                   tgt_failed;

  // out of range or failed source falls back to clock 0
  assign req_bad = (int'(req.idx) >= CLK_NUM) || clk_fail[req.idx];

  assign req_onehot = req_bad ? clk_ctrl_pkg::CLK0_VEC
                              : clk_ctrl_pkg::CLK0_VEC << req.idx;

  // one switch in flight at a time
  assign req_ready = !busy;
  assign accept    = req_valid && req_ready;

  // current target has stopped toggling
  assign tgt_failed = |(target & clk_fail);

  // ============================================================
  // target, fallback and busy
  // ============================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      target   <= clk_ctrl_pkg::CLK0_VEC;
      fallback <= 1'b0;
      busy     <= 1'b0;
    end else if (accept) begin
      target   <= req_onehot;
      fallback <= req_bad;
      busy     <= 1'b1;
    end else begin
      // busy ends with the response handshake
      if (done) begin
        busy <= 1'b0;
      end
      // lost source, move to clock 0 without a new response
      if (tgt_failed) begin
        target   <= clk_ctrl_pkg::CLK0_VEC;
        fallback <= 1'b1;
      end
    end
  end

  // switch and status rely on exactly one target bit
  a_target_onehot : assert property (
    @(posedge clk) disable iff (reset)
    $onehot(target)
  );

endmodule

// File: source/clk_ctrl_pkg.sv
// clock controller shared definitions
// index and per-clock vector types, request and response structs,
// width constants and the default fail timeout
package clk_ctrl_pkg;

  // index width, enough for up to four clocks
  localparam int CLK_SEL_W = 2;
  localparam int CLK_MAX   = 1 << CLK_SEL_W;

  // reference cycles without a toggle before a clock counts as failed
  localparam int FAIL_TIMEOUT_DEF = 16;

  // clock index
  typedef logic [CLK_SEL_W-1:0] clk_idx_t;

  // one-hot select or per-clock flags, unused upper bits stay zero
  typedef logic [CLK_MAX-1:0] clk_vec_t;

  // one-hot of the always-on reference clock
  localparam clk_vec_t CLK0_VEC = clk_vec_t'(1);

  // ============================================================
  // request and response channel payloads
  // ============================================================

  typedef struct packed {
    clk_idx_t idx;
  } sel_req_t;

  typedef struct packed {
    clk_idx_t active;    // clock now driving the output
    logic     fallback;  // request replaced by clock 0
    clk_vec_t failed;    // fail flags at completion
  } sel_rsp_t;

endpackage
